// ==== sources.f ====
hdl/gb_bus_pkg.sv
hdl/bus_cycle_fsm.sv
hdl/wait_timer.sv
hdl/bus_strobe_gen.sv
hdl/data_latch.sv
hdl/bus_memory.sv
hdl/gb_bus_top.sv
tb/gb_bus_chk.sv
tb/tb_gb_bus.sv

// ==== Makefile ====
# Verilator build and run for the Game Boy bus-cycle subsystem

VERILATOR ?= verilator
SIM_DIR   ?= obj_dir
TOP       ?= tb_gb_bus
SEED_ARGS ?= +verilator+seed+24
RUN_ARGS  ?= +verilator+error+limit+100
VFLAGS    ?= --binary --assert -j 0
FILELIST  ?= sources.f
LOG       ?= $(SIM_DIR)/sim.log

SOURCES := $(wildcard hdl/*.sv) $(wildcard tb/*.sv)
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# The binary is rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the log
run: $(SIM_BIN)
	-$(SIM_BIN) $(SEED_ARGS) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(SIM_DIR)

// ==== tb/tb_gb_bus.sv ====
`timescale 1ns/1ns

module tb_gb_bus;
    import gb_bus_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int ACK_TIMEOUT = 64;
    localparam int N_RANDOM    = 48;
    localparam int MEM_LAT     = 4;

    // One bus operation with its expected read byte and the extra req hold time
    typedef struct packed {
        bus_op_e     op;
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        chk;
        logic [7:0]  exp;
        logic [1:0]  hold;
    } stim_t;

    logic        CLK_n = 1'b0;
    logic        RESET_n;
    logic        clken = 1'b1;
    logic        req;
    bus_req_t    req_data;
    logic        ack;
    bus_rsp_t    rsp;
    bus_strobe_t strb;

    stim_t      stim_q[$];
    logic [7:0] ram_model [0:(1 << RAM_AW) - 1];
    logic       ram_known [0:(1 << RAM_AW) - 1];
    logic [7:0] io_model [0:IO_REGS - 1];

    int errors;
    int mon_errors;
    int timeouts;
    int n_directed;
    int m1_count;
    bit gaps_on;

    gb_bus_top DUT (
        .CLK_n    (CLK_n),
        .RESET_n  (RESET_n),
        .clken    (clken),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp),
        .strb     (strb)
    );

    always #(CLK_PERIOD / 2) CLK_n = ~CLK_n;

    // Clock enable runs free during the directed part and gets random gaps later
    always @(negedge CLK_n) begin
        if (gaps_on) begin
            clken <= (($urandom % 4) != 0);
        end else begin
            clken <= 1'b1;
        end
    end

    // Strobes are stable at the rising edge and still match the T-state before it moves
    always @(posedge CLK_n) begin
        if (RESET_n) begin
            if (!strb.m1_n) begin
                m1_count++;
            end
            if ((DUT.tstate == TS_IDLE) && (strb !== '1)) begin
                mon_errors++;
                $display("Error: %0t ns: strobes %b active while idle", $time, strb);
            end
            if (!strb.rd_n && !strb.wr_n) begin
                mon_errors++;
                $display("Error: %0t ns: rd_n and wr_n low together", $time);
            end
            if (!strb.mreq_n && !strb.iorq_n) begin
                mon_errors++;
                $display("Error: %0t ns: mreq_n and iorq_n low together", $time);
            end
            if (!strb.wr_n && (DUT.tstate != TS_T2) && (DUT.tstate != TS_T3)) begin
                mon_errors++;
                $display("Error: %0t ns: wr_n low outside T2 and T3", $time);
            end
        end
    end

    // A write updates the model, so later reads know which byte to expect
    task automatic add_write(input bus_op_e op, input logic [15:0] addr, input logic [7:0] data);
        stim_t s;
        s.op    = op;
        s.addr  = addr;
        s.wdata = data;
        s.chk   = 1'b0;
        s.exp   = 8'h00;
        s.hold  = 2'($urandom % 4);
        if (op == OP_IO_WR) begin
            io_model[addr[3:0]] = data;
        end else begin
            ram_model[addr[RAM_AW-1:0]] = data;
            ram_known[addr[RAM_AW-1:0]] = 1'b1;
        end
        stim_q.push_back(s);
    endtask

    task automatic add_read(input bus_op_e op, input logic [15:0] addr);
        stim_t s;
        s.op    = op;
        s.addr  = addr;
        s.wdata = 8'h00;
        s.chk   = 1'b1;
        s.hold  = 2'($urandom % 4);
        if (op == OP_IO_RD) begin
            s.exp = io_model[addr[3:0]];
        end else begin
            s.exp = ram_model[addr[RAM_AW-1:0]];
        end
        stim_q.push_back(s);
    endtask

    task automatic build_table();
        int          kind;
        logic [15:0] a;
        for (int i = 0; i < (1 << RAM_AW); i++) begin
            ram_known[i] = 1'b0;
        end
        // I/O registers come out of reset cleared
        for (int i = 0; i < IO_REGS; i++) begin
            io_model[i] = 8'h00;
        end
        add_read(OP_IO_RD, 16'hFF05);
        add_write(OP_MEM_WR, 16'h0123, 8'hA5);
        add_read(OP_MEM_RD, 16'h0123);
        add_read(OP_FETCH, 16'h0123);
        add_write(OP_MEM_WR, 16'h03FF, 8'h5A);
        add_read(OP_FETCH, 16'h03FF);
        add_read(OP_MEM_RD, 16'h03FF);
        for (int i = 0; i < IO_REGS; i++) begin
            add_write(OP_IO_WR, {IO_PAGE, 8'(i)}, 8'(i * 37 + 11));
        end
        // Reading back in reverse order shows that each index hits its own register
        for (int i = IO_REGS - 1; i >= 0; i--) begin
            add_read(OP_IO_RD, {IO_PAGE, 8'(i)});
        end
        n_directed = stim_q.size();
        for (int n = 0; n < N_RANDOM; n++) begin
            kind = int'($urandom % 5);
            a    = 16'h0200 + 16'($urandom % 8);
            if (kind == 0) begin
                add_write(OP_MEM_WR, a, 8'($urandom));
            end else if ((kind == 1) || (kind == 2)) begin
                // RAM is not reset, so a location is written before it is read
                if (ram_known[a[RAM_AW-1:0]]) begin
                    add_read((kind == 1) ? OP_MEM_RD : OP_FETCH, a);
                end else begin
                    add_write(OP_MEM_WR, a, 8'($urandom));
                end
            end else if (kind == 3) begin
                add_write(OP_IO_WR, {IO_PAGE, 8'($urandom % 16)}, 8'($urandom));
            end else begin
                add_read(OP_IO_RD, {IO_PAGE, 8'($urandom % 16)});
            end
        end
    endtask

    // Polls ack on falling edges, counting the edges until it reaches the level
    task automatic wait_ack(input logic level, output int cycles, output bit timed_out);
        @(negedge CLK_n);
        cycles = 1;
        while ((ack !== level) && (cycles < ACK_TIMEOUT)) begin
            @(negedge CLK_n);
            cycles++;
        end
        timed_out = (ack !== level);
    endtask

    task automatic run_entry(input int idx, input stim_t s);
        int cycles;
        bit tmo;
        int exp_lat;
        int m1_start;
        bit is_fetch;
        is_fetch = (s.op == OP_FETCH);
        // I/O cycles carry the wait states on top of the plain memory cycle
        exp_lat = ((s.op == OP_IO_RD) || (s.op == OP_IO_WR)) ? MEM_LAT + IO_WAIT : MEM_LAT;
        req_data.op       = s.op;
        req_data.addr.raw = s.addr;
        req_data.wdata    = s.wdata;
        m1_start = m1_count;
        req = 1'b1;
        wait_ack(1'b1, cycles, tmo);
        if (tmo) begin
            timeouts++;
            $display("Timeout at %0t ns: ack never rose for entry %0d", $time, idx);
            req = 1'b0;
        end else begin
            if (!gaps_on && (cycles != exp_lat)) begin
                errors++;
                $display("Error: %0t ns: entry %0d latency %0d, expected %0d",
                         $time, idx, cycles, exp_lat);
            end
            if (s.chk && (rsp.rdata !== s.exp)) begin
                errors++;
                $display("Error: %0t ns: entry %0d read %h, expected %h",
                         $time, idx, rsp.rdata, s.exp);
            end
            if (is_fetch != (m1_count != m1_start)) begin
                errors++;
                $display("Error: %0t ns: entry %0d m1_n activity does not match the op",
                         $time, idx);
            end
            // Back-pressure, ack must stay up for as long as req is held
            for (int k = 0; k < int'(s.hold); k++) begin
                @(negedge CLK_n);
                if (ack !== 1'b1) begin
                    errors++;
                    $display("Error: %0t ns: entry %0d ack dropped with req high", $time, idx);
                end
            end
            req = 1'b0;
            wait_ack(1'b0, cycles, tmo);
            if (tmo) begin
                timeouts++;
                $display("Timeout at %0t ns: ack never fell for entry %0d", $time, idx);
            end else if (!gaps_on && (cycles != 1)) begin
                errors++;
                $display("Error: %0t ns: entry %0d ack fell after %0d cycles", $time, idx, cycles);
            end
        end
    endtask

    initial begin
        int seed_val;
        seed_val   = $urandom(24);
        errors     = 0;
        mon_errors = 0;
        timeouts   = 0;
        m1_count   = 0;
        gaps_on    = 1'b0;
        RESET_n    = 1'b0;
        req        = 1'b0;
        req_data   = '0;
        build_table();
        repeat (10) @(negedge CLK_n);
        RESET_n = 1'b1;
        repeat (2) @(negedge CLK_n);
        if (ack !== 1'b0) begin
            errors++;
            $display("Error: %0t ns: ack is high after reset", $time);
        end
        for (int i = 0; (i < stim_q.size()) && (timeouts == 0); i++) begin
            // Gaps switch on between cycles, away from the edge where clken is driven
            if (i == n_directed) begin
                @(posedge CLK_n);
                gaps_on = 1'b1;
                @(negedge CLK_n);
            end
            run_entry(i, stim_q[i]);
        end
        $display("Entries %0d, errors %0d, monitor errors %0d, timeouts %0d",
                 stim_q.size(), errors, mon_errors, timeouts);
        if ((errors == 0) && (mon_errors == 0) && (timeouts == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/gb_bus_chk.sv ====
`timescale 1ns/1ns

module gb_bus_chk
    import gb_bus_pkg::*;
(
    input logic        CLK_n,
    input logic        RESET_n,
    input logic        req,
    input logic        ack,
    input bus_strobe_t strb,
    input tstate_e     tstate
);

    // Strobes move on the falling edge, so every property samples on the rising edge
    a_rd_wr_excl: assert property (@(posedge CLK_n) disable iff (!RESET_n)
        !(!strb.rd_n && !strb.wr_n))
        else $error("rd_n and wr_n are low at the same time");

    a_mreq_iorq_excl: assert property (@(posedge CLK_n) disable iff (!RESET_n)
        !(!strb.mreq_n && !strb.iorq_n))
        else $error("mreq_n and iorq_n are low at the same time");

    // The sampled T-state is the one the strobes were decoded from
    a_wr_in_access: assert property (@(posedge CLK_n) disable iff (!RESET_n)
        !strb.wr_n |-> ((tstate == TS_T2) || (tstate == TS_T3)))
        else $error("wr_n is low outside T2 and T3");

    // Four-phase return, ack may only drop once req was seen low
    a_ack_fall: assert property (@(posedge CLK_n) disable iff (!RESET_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    a_ack_hold: assert property (@(posedge CLK_n) disable iff (!RESET_n)
        (ack && req) |=> ack)
        else $error("ack dropped while req was held high");

endmodule

bind gb_bus_top gb_bus_chk u_chk (
    .CLK_n   (CLK_n),
    .RESET_n (RESET_n),
    .req     (req),
    .ack     (ack),
    .strb    (strb),
    .tstate  (tstate)
);

// ==== hdl/gb_bus_top.sv ====
`timescale 1ns/1ns

module gb_bus_top
    import gb_bus_pkg::*;
(
    input  logic        CLK_n,
    input  logic        RESET_n,
    input  logic        clken,
    input  logic        req,
    input  bus_req_t    req_data,
    output logic        ack,
    output bus_rsp_t    rsp,
    output bus_strobe_t strb
);

    tstate_e    tstate;
    bus_req_t   cur;
    logic       wait_n;
    logic [7:0] mem_di;
    logic [7:0] rdata;

    // Request handshake and T-state sequencing
    bus_cycle_fsm u_fsm (
        .CLK_n    (CLK_n),
        .RESET_n  (RESET_n),
        .clken    (clken),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp),
        .wait_n   (wait_n),
        .rdata    (rdata),
        .tstate   (tstate),
        .cur      (cur)
    );

    // Stretches T2 of I/O cycles
    wait_timer u_wait (
        .CLK_n   (CLK_n),
        .RESET_n (RESET_n),
        .clken   (clken),
        .strb    (strb),
        .wait_n  (wait_n)
    );

    bus_strobe_gen u_strobe (
        .CLK_n   (CLK_n),
        .RESET_n (RESET_n),
        .tstate  (tstate),
        .cur     (cur),
        .strb    (strb)
    );

    data_latch u_latch (
        .CLK_n   (CLK_n),
        .RESET_n (RESET_n),
        .clken   (clken),
        .tstate  (tstate),
        .cur     (cur),
        .wait_n  (wait_n),
        .mem_di  (mem_di),
        .rdata   (rdata)
    );

    // RAM and I/O registers sitting on the strobed bus
    bus_memory u_mem (
        .CLK_n   (CLK_n),
        .RESET_n (RESET_n),
        .strb    (strb),
        .addr    (cur.addr),
        .dout    (cur.wdata),
        .mem_di  (mem_di)
    );

endmodule

// ==== hdl/bus_memory.sv ====
`timescale 1ns/1ns

module bus_memory
    import gb_bus_pkg::*;
(
    input  logic        CLK_n,
    input  logic        RESET_n,
    input  bus_strobe_t strb,
    input  bus_addr_u   addr,
    input  logic [7:0]  dout,
    output logic [7:0]  mem_di
);

    logic [7:0] ram [0:(1 << RAM_AW) - 1];
    logic [7:0] io_regs [0:IO_REGS - 1];

    logic              io_sel;
    logic [RAM_AW-1:0] ram_addr;
    logic [IO_AW-1:0]  io_idx;

    // Same address word, decoded as a flat memory address or as page and register
    assign ram_addr = addr.raw[RAM_AW-1:0];
    assign io_idx   = addr.io.index[IO_AW-1:0];
    assign io_sel   = (addr.io.page == IO_PAGE);

    // Writes repeat on each rising edge of the write pulse with the same data,
    // the last one lands at the end of T3
    always_ff @(posedge CLK_n) begin
        if (!strb.wr_n && !strb.mreq_n) begin
            ram[ram_addr] <= dout;
        end
    end

    // I/O registers come up cleared
    always_ff @(posedge CLK_n or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < IO_REGS; i++) begin
                io_regs[i] <= 8'h00;
            end
        end else if (!strb.wr_n && !strb.iorq_n && io_sel) begin
            io_regs[io_idx] <= dout;
        end
    end

    // Read path is combinational while rd_n is low, an undriven bus reads as FF
    always_comb begin
        mem_di = 8'hFF;
        if (!strb.rd_n) begin
            if (!strb.mreq_n) begin
                mem_di = ram[ram_addr];
            end else if (!strb.iorq_n && io_sel) begin
                mem_di = io_regs[io_idx];
            end
        end
    end

endmodule

// ==== hdl/data_latch.sv ====
`timescale 1ns/1ns

module data_latch
    import gb_bus_pkg::*;
(
    input  logic       CLK_n,
    input  logic       RESET_n,
    input  logic       clken,
    input  tstate_e    tstate,
    input  bus_req_t   cur,
    input  logic       wait_n,
    input  logic [7:0] mem_di,
    output logic [7:0] rdata
);

    logic wait_q;
    logic wait_rise;
    logic capture;

    assign wait_rise = !wait_q && wait_n;

    // Normal capture when T3 of a read completes, plus a one-shot when the wait
    // state ends so the byte is already held before the cycle resumes
    assign capture = op_is_read(cur.op) && wait_n &&
                     ((clken && (tstate == TS_T3)) ||
                      (wait_rise && ((tstate == TS_T2) || (tstate == TS_T3))));

    always_ff @(posedge CLK_n or negedge RESET_n) begin
        if (!RESET_n) begin
            rdata  <= 8'h00;
            wait_q <= 1'b1;
        end else begin
            if (capture) begin
                rdata <= mem_di;
            end
            wait_q <= wait_n;
        end
    end

endmodule

// ==== hdl/bus_strobe_gen.sv ====
`timescale 1ns/1ns

module bus_strobe_gen
    import gb_bus_pkg::*;
(
    input  logic        CLK_n,
    input  logic        RESET_n,
    input  tstate_e     tstate,
    input  bus_req_t    cur,
    output bus_strobe_t strb
);

    logic is_rd;
    logic is_io;
    logic in_access;

    assign is_rd = op_is_read(cur.op);
    assign is_io = op_is_io(cur.op);

    // Data phase of the cycle, T2 including any wait states, and T3
    assign in_access = (tstate == TS_T2) || (tstate == TS_T3);

    // The T-state moves on the rising edge, so sampling it on the falling edge
    // gives strobes that follow the settled state of the current cycle
    always_ff @(negedge CLK_n or negedge RESET_n) begin
        if (!RESET_n) begin
            strb <= '1;
        end else begin
            // Everything idles high unless the decode below pulls it low
            strb <= '1;

            if (cur.op == OP_FETCH) begin
                // Opcode fetch, m1_n spans the whole cycle
                if (tstate != TS_IDLE) begin
                    strb.m1_n <= 1'b0;
                end
                if (in_access) begin
                    strb.rd_n   <= 1'b0;
                    strb.mreq_n <= 1'b0;
                end
            end else begin
                // Memory or I/O read
                if (in_access && is_rd) begin
                    strb.rd_n   <= 1'b0;
                    strb.iorq_n <= !is_io;
                    strb.mreq_n <= is_io;
                end

                // Writes drive wr_n through T2 and T3, data has been stable since T1
                if (in_access && !is_rd) begin
                    strb.wr_n   <= 1'b0;
                    strb.iorq_n <= !is_io;
                    strb.mreq_n <= is_io;
                end
            end
        end
    end

endmodule

// ==== hdl/wait_timer.sv ====
`timescale 1ns/1ns

module wait_timer
    import gb_bus_pkg::*;
(
    input  logic        CLK_n,
    input  logic        RESET_n,
    input  logic        clken,
    input  bus_strobe_t strb,
    output logic        wait_n
);

    logic               iorq_q;
    logic               iorq_fall;
    logic [WAIT_CW-1:0] count;

    // iorq_n drops on the falling edge, so the next rising edge sees it here first
    assign iorq_fall = iorq_q && !strb.iorq_n;

    // The fall itself already holds off the cycle, which uses up one wait state
    // when the enable is high on that edge
    always_ff @(posedge CLK_n or negedge RESET_n) begin
        if (!RESET_n) begin
            iorq_q <= 1'b1;
            count  <= '0;
        end else begin
            iorq_q <= strb.iorq_n;
            if (iorq_fall) begin
                count <= clken ? WAIT_CW'(IO_WAIT - 1) : WAIT_CW'(IO_WAIT);
            end else if (clken && (count != '0)) begin
                count <= count - 1'b1;
            end
        end
    end

    // Memory cycles never assert iorq_n and so never see a wait state
    assign wait_n = !(iorq_fall || (count != '0));

endmodule

// ==== hdl/bus_cycle_fsm.sv ====
`timescale 1ns/1ns

module bus_cycle_fsm
    import gb_bus_pkg::*;
(
    input  logic     CLK_n,
    input  logic     RESET_n,
    input  logic     clken,
    input  logic     req,
    input  bus_req_t req_data,
    output logic     ack,
    output bus_rsp_t rsp,
    input  logic     wait_n,
    input  logic [7:0] rdata,
    output tstate_e  tstate,
    output bus_req_t cur
);

    logic accept;

    // A request is taken only from idle, and only once the previous ack has dropped
    assign accept = clken && (tstate == TS_IDLE) && !ack && req;

    // The request is held for the whole cycle so the requester side may settle freely
    always_ff @(posedge CLK_n) begin
        if (accept) begin
            cur <= req_data;
        end
    end

    // T-state walk, every step is qualified by the clock enable
    always_ff @(posedge CLK_n or negedge RESET_n) begin
        if (!RESET_n) begin
            tstate <= TS_IDLE;
            ack    <= 1'b0;
        end else if (clken) begin
            case (tstate)
                TS_IDLE: begin
                    // Four-phase return, ack follows req down one enabled edge later
                    if (ack) begin
                        if (!req) begin
                            ack <= 1'b0;
                        end
                    end else if (req) begin
                        tstate <= TS_T1;
                    end
                end
                TS_T1: begin
                    tstate <= TS_T2;
                end
                TS_T2: begin
                    // Wait states stretch T2 until the timer releases wait_n
                    if (wait_n) begin
                        tstate <= TS_T3;
                    end
                end
                TS_T3: begin
                    // Read data was latched on this same edge, so rsp is valid with ack
                    tstate <= TS_IDLE;
                    ack    <= 1'b1;
                end
                default: begin
                    tstate <= TS_IDLE;
                end
            endcase
        end
    end

    // Latched byte is only presented while the cycle is being acknowledged
    always_comb begin
        rsp.rdata = ack ? rdata : 8'h00;
    end

endmodule

// ==== hdl/gb_bus_pkg.sv ====
package gb_bus_pkg;

    // Number of wait states added to every I/O access
    localparam int IO_WAIT = 2;

    // The RAM is 1 KiB, addressed by the low bits of the raw view
    localparam int RAM_AW = 10;

    // I/O register file on page FF
    localparam int IO_REGS = 16;
    localparam int IO_AW = $clog2(IO_REGS);
    localparam logic [7:0] IO_PAGE = 8'hFF;

    // Width of the wait-state counter, wide enough to hold IO_WAIT
    localparam int WAIT_CW = $clog2(IO_WAIT + 1);

    // Bus operation requested by the requester
    typedef enum logic [2:0] {
        OP_FETCH  = 3'd0,
        OP_MEM_RD = 3'd1,
        OP_MEM_WR = 3'd2,
        OP_IO_RD  = 3'd3,
        OP_IO_WR  = 3'd4
    } bus_op_e;

    // T-state of the running bus cycle, idle between cycles
    typedef enum logic [1:0] {
        TS_IDLE = 2'd0,
        TS_T1   = 2'd1,
        TS_T2   = 2'd2,
        TS_T3   = 2'd3
    } tstate_e;

    // I/O view of the address: high byte is the page, low byte the register
    typedef struct packed {
        logic [7:0] page;
        logic [7:0] index;
    } bus_io_addr_t;

    // Memory cycles use the raw address, I/O cycles decode page and index
    typedef union packed {
        logic [15:0]  raw;
        bus_io_addr_t io;
    } bus_addr_u;

    typedef struct packed {
        bus_op_e    op;
        bus_addr_u  addr;
        logic [7:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [7:0] rdata;
    } bus_rsp_t;

    // All strobes are active low
    typedef struct packed {
        logic m1_n;
        logic mreq_n;
        logic iorq_n;
        logic rd_n;
        logic wr_n;
    } bus_strobe_t;

    // An opcode fetch is a memory read with m1_n on top
    function automatic logic op_is_read(bus_op_e op);
        return (op == OP_FETCH) || (op == OP_MEM_RD) || (op == OP_IO_RD);
    endfunction

    function automatic logic op_is_io(bus_op_e op);
        return (op == OP_IO_RD) || (op == OP_IO_WR);
    endfunction

endpackage
